// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0 -Wno-fatal
TOP       ?= fft_tb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "RESULT: PASS" $(LOG) || { echo "no result line in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: design/fft_buffer.sv
module fft_buffer import fft_num_pkg::*, fft_ctrl_pkg::*; (
	input logic clk,
	input logic reset,
	fft_stage_if.result cmd,
	input sample_t sample_in [N_POINTS],
	input data_t calc_real [N_POINTS],
	input data_t calc_imag [N_POINTS],
	output data_t work_real [N_POINTS],
	output data_t work_imag [N_POINTS]
);

	data_t next_real [N_POINTS];
	data_t next_imag [N_POINTS];

	function automatic point_idx_t bit_rev(input point_idx_t idx);
		point_idx_t rev;
		for (int b = 0; b < LOG2_N; b++) begin
			rev[b] = idx[LOG2_N-1-b];
		end
		return rev;
	endfunction

	always_comb begin
		next_real = work_real;    // hold by default
		next_imag = work_imag;
		case (cmd.op)
			OP_LOAD: begin
				for (int i = 0; i < N_POINTS; i++) begin
					next_real[i] = {{(DATA_W - SAMPLE_W){1'b0}}, sample_in[i]};  // unsigned samples
					next_imag[i] = '0;
				end
			end
			OP_BUTTERFLY, OP_TWIDDLE: begin
				next_real = calc_real;
				next_imag = calc_imag;
			end
			OP_REORDER: begin
				for (int i = 0; i < N_POINTS; i++) begin
					next_real[bit_rev(point_idx_t'(i))] = work_real[i];
					next_imag[bit_rev(point_idx_t'(i))] = work_imag[i];
				end
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			work_real <= '{default: '0};
			work_imag <= '{default: '0};
		end else begin
			work_real <= next_real;
			work_imag <= next_imag;
		end
	end

endmodule

// File: design/fft_ctrl_pkg.sv
package fft_ctrl_pkg;
	import fft_num_pkg::*;

	// bottom-half points are covered MUL_LANES at a time
	localparam int MUL_GROUPS = N_POINTS / 2 / MUL_LANES;
	localparam int MUL_GROUP_W = (MUL_GROUPS > 1) ? $clog2(MUL_GROUPS) : 1;

	typedef logic [3:0] stage_sel_t;
	typedef logic [MUL_GROUP_W-1:0] mul_group_t;
	typedef logic [$clog2(LOG2_N)-1:0] span_log_t;   // log2 of butterfly span

	typedef enum logic [2:0] {
		OP_HOLD,
		OP_LOAD,
		OP_BUTTERFLY,
		OP_TWIDDLE,
		OP_REORDER
	} fft_op_e;

	// 2p is a butterfly, 2p+1 the twiddle pass that follows it
	localparam stage_sel_t STAGE_LOAD = stage_sel_t'(1);
	localparam stage_sel_t STAGE_REORDER = stage_sel_t'(2 * LOG2_N + 1);

endpackage

// File: design/fft_execute.sv
module fft_execute import fft_num_pkg::*, fft_ctrl_pkg::*; (
	fft_stage_if.execute cmd,
	input data_t work_real [N_POINTS],
	input data_t work_imag [N_POINTS],
	output data_t calc_real [N_POINTS],
	output data_t calc_imag [N_POINTS]
);

	data_t bf_real [N_POINTS];
	data_t bf_imag [N_POINTS];
	data_t mul_real [MUL_LANES];
	data_t mul_imag [MUL_LANES];

	// butterfly bank, all N_POINTS/2 pairs at once
	always_comb begin
		int s_log;
		int a;
		int b;
		s_log = int'(cmd.span_log);
		bf_real = work_real;
		bf_imag = work_imag;
		for (int j = 0; j < N_POINTS / 2; j++) begin
			a = ((j >> s_log) << (s_log + 1)) + (j % (1 << s_log));
			b = a + (1 << s_log);
			bf_real[a] = work_real[a] + work_real[b];   // wraps at DATA_W
			bf_imag[a] = work_imag[a] + work_imag[b];
			bf_real[b] = work_real[a] - work_real[b];
			bf_imag[b] = work_imag[a] - work_imag[b];
		end
	end

	for (genvar l = 0; l < MUL_LANES; l++) begin : g_lane
		data_t in_re;
		data_t in_im;
		data_t tw_re;
		data_t tw_im;
		logic signed [2*DATA_W:0] prod_re;   // extra bit for -1 * -1 cases
		logic signed [2*DATA_W:0] prod_im;

		assign in_re = work_real[cmd.lane_addr[l]];
		assign in_im = work_imag[cmd.lane_addr[l]];
		assign tw_re = TWIDDLE_COS[cmd.lane_twiddle[l]];
		assign tw_im = TWIDDLE_NSIN[cmd.lane_twiddle[l]];

		assign prod_re = in_re * tw_re - in_im * tw_im;
		assign prod_im = in_re * tw_im + in_im * tw_re;

		// back to Q0, keep the low DATA_W bits
		assign mul_real[l] = data_t'(prod_re >>> FRAC_W);
		assign mul_imag[l] = data_t'(prod_im >>> FRAC_W);
	end

	always_comb begin
		calc_real = work_real;
		calc_imag = work_imag;
		if (cmd.op == OP_BUTTERFLY) begin
			calc_real = bf_real;
			calc_imag = bf_imag;
		end else if (cmd.op == OP_TWIDDLE) begin
			// only the addressed points change
			for (int l = 0; l < MUL_LANES; l++) begin
				calc_real[cmd.lane_addr[l]] = mul_real[l];
				calc_imag[cmd.lane_addr[l]] = mul_imag[l];
			end
		end
	end

endmodule

// File: design/fft_num_pkg.sv
package fft_num_pkg;

	localparam int N_POINTS = 16;
	localparam int LOG2_N = 4;          // butterfly stages
	localparam int SAMPLE_W = 8;
	localparam int DATA_W = 16;
	localparam int FRAC_W = 15;         // Q15 twiddles
	localparam int MUL_LANES = 4;

	typedef logic [SAMPLE_W-1:0] sample_t;
	typedef logic signed [DATA_W-1:0] data_t;
	typedef logic [LOG2_N-1:0] point_idx_t;
	typedef logic [LOG2_N-2:0] twiddle_idx_t;

	// entry k holds round(32767 * cos(2*pi*k/N_POINTS))
	localparam data_t TWIDDLE_COS [N_POINTS/2] = '{
		16'sd32767,
		16'sd30273,
		16'sd23170,
		16'sd12539,
		16'sd0,
		-16'sd12539,
		-16'sd23170,
		-16'sd30273
	};

	// entry k holds round(-32767 * sin(2*pi*k/N_POINTS))
	// minus one at k = N_POINTS/4 uses the full negative code
	localparam data_t TWIDDLE_NSIN [N_POINTS/2] = '{
		16'sd0,
		-16'sd12539,
		-16'sd23170,
		-16'sd30273,
		-16'sd32768,
		-16'sd30273,
		-16'sd23170,
		-16'sd12539
	};

endpackage

// File: design/fft_stage_decode.sv
module fft_stage_decode import fft_num_pkg::*, fft_ctrl_pkg::*; (
	input stage_sel_t stage_select,
	input mul_group_t mul_count,
	fft_stage_if.decode cmd
);

	fft_op_e op;
	span_log_t span_log;

	// stage code to operation and span
	always_comb begin
		int pass;
		pass = int'(stage_select >> 1);
		op = OP_HOLD;
		span_log = '0;
		if (stage_select == STAGE_LOAD) begin
			op = OP_LOAD;
		end else if (stage_select == STAGE_REORDER) begin
			op = OP_REORDER;
		end else if (pass >= 1 && pass <= LOG2_N) begin
			if (!stage_select[0]) begin
				op = OP_BUTTERFLY;                 // span is N_POINTS >> pass
				span_log = span_log_t'(LOG2_N - pass);
			end else if (pass < LOG2_N) begin
				op = OP_TWIDDLE;
				span_log = span_log_t'(LOG2_N - pass);
			end
		end
	end

	assign cmd.op = op;
	assign cmd.span_log = span_log;

	// lane l takes bottom-half point k = group * MUL_LANES + l
	always_comb begin
		int k;
		int s_log;
		int off;
		s_log = int'(span_log);
		for (int l = 0; l < MUL_LANES; l++) begin
			k = int'(mul_count) * MUL_LANES + l;
			off = k % (1 << s_log);      // position inside the bottom half
			cmd.lane_addr[l] = point_idx_t'(((k >> s_log) << (s_log + 1)) + (1 << s_log) + off);
			// step through the table at N_POINTS / (2 * span)
			cmd.lane_twiddle[l] = twiddle_idx_t'(off << (LOG2_N - 1 - s_log));
		end
	end

endmodule

// File: design/fft_stage_if.sv
interface fft_stage_if import fft_num_pkg::*, fft_ctrl_pkg::*; ();

	fft_op_e op;
	span_log_t span_log;
	point_idx_t lane_addr [MUL_LANES];       // bottom-half point per multiplier
	twiddle_idx_t lane_twiddle [MUL_LANES];

	modport decode (
		output op,
		output span_log,
		output lane_addr,
		output lane_twiddle
	);

	modport execute (
		input op,
		input span_log,
		input lane_addr,
		input lane_twiddle
	);

	modport result (input op);

endinterface

// File: design/fft_top.sv
module fft_top import fft_num_pkg::*, fft_ctrl_pkg::*; (
	input logic clk,
	input logic reset,
	input sample_t sample_in [N_POINTS],
	input stage_sel_t stage_select,
	input mul_group_t mul_count,
	output data_t out_real [N_POINTS],
	output data_t out_imag [N_POINTS]
);

	data_t calc_real [N_POINTS];
	data_t calc_imag [N_POINTS];

	fft_stage_if stage_if ();

	// command decode, purely combinational
	fft_stage_decode u_decode (
		.stage_select (stage_select),
		.mul_count    (mul_count),
		.cmd          (stage_if.decode)
	);

	// next buffer contents from the current ones
	fft_execute u_execute (
		.cmd       (stage_if.execute),
		.work_real (out_real),
		.work_imag (out_imag),
		.calc_real (calc_real),
		.calc_imag (calc_imag)
	);

	// the working buffer is the output
	fft_buffer u_buffer (
		.clk       (clk),
		.reset     (reset),
		.cmd       (stage_if.result),
		.sample_in (sample_in),
		.calc_real (calc_real),
		.calc_imag (calc_imag),
		.work_real (out_real),
		.work_imag (out_imag)
	);

endmodule

// File: dv/fft_tb_model.svh
// reference model, stimulus source and value checks for fft_tb

localparam real PI = 3.14159265358979;

logic [31:0] lfsr_state = 32'hf34e4d40;
int model_re [N_POINTS];
int model_im [N_POINTS];
int tw_cos [N_POINTS/2];
int tw_nsin [N_POINTS/2];
int err_count = 0;
int check_count = 0;

// fibonacci lfsr, taps 32 22 2 1, one step per bit taken
function automatic int rand_bits(input int n);
	int v;
	logic fb;
	v = 0;
	for (int i = 0; i < n; i++) begin
		fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
		lfsr_state = {lfsr_state[30:0], fb};
		v = (v << 1) | int'(fb);
	end
	return v;
endfunction

function automatic int wrap16(input longint v);
	data_t t;
	t = v[DATA_W-1:0];
	return int'(t);
endfunction

function automatic int bit_reverse(input int i);
	int r;
	r = 0;
	for (int b = 0; b < LOG2_N; b++) begin
		r = (r << 1) | ((i >> b) & 1);
	end
	return r;
endfunction

function automatic int q15(input real x);
	int v;
	v = (x >= 0.0) ? $rtoi(x * 32767.0 + 0.5) : -$rtoi(0.5 - x * 32767.0);
	return (v == -32767) ? -32768 : v;   // full negative one
endfunction

task automatic build_twiddles();
	for (int k = 0; k < N_POINTS / 2; k++) begin
		tw_cos[k] = q15($cos(2.0 * PI * k / N_POINTS));
		tw_nsin[k] = q15(-$sin(2.0 * PI * k / N_POINTS));
	end
endtask

task automatic check(input string name, input int expected, input int actual);
	check_count++;
	if (expected != actual) begin
		err_count++;
		$display("ERR %s: expected %0d, actual %0d", name, expected, actual);
	end
endtask

// one command applied to the model buffer
task automatic model_apply(input int stage, input int group);
	int nre [N_POINTS];
	int nim [N_POINTS];
	int pass;
	int s;
	int a;
	int k;
	int t;
	longint p_re;
	longint p_im;
	nre = model_re;
	nim = model_im;
	pass = stage / 2;
	s = N_POINTS >> pass;
	if (stage == 1) begin
		foreach (nre[i]) begin
			nre[i] = int'(sample_in[i]);
			nim[i] = 0;
		end
	end else if (stage == 2 * LOG2_N + 1) begin
		foreach (nre[i]) begin
			nre[bit_reverse(i)] = model_re[i];
			nim[bit_reverse(i)] = model_im[i];
		end
	end else if (stage % 2 == 0 && pass >= 1 && pass <= LOG2_N) begin
		for (int g = 0; g < N_POINTS; g += 2 * s) begin
			for (int i = 0; i < s; i++) begin
				a = g + i;
				nre[a] = wrap16(model_re[a] + model_re[a + s]);
				nim[a] = wrap16(model_im[a] + model_im[a + s]);
				nre[a + s] = wrap16(model_re[a] - model_re[a + s]);
				nim[a + s] = wrap16(model_im[a] - model_im[a + s]);
			end
		end
	end else if (stage % 2 == 1 && pass >= 1 && pass < LOG2_N) begin
		for (int l = 0; l < MUL_LANES; l++) begin
			k = group * MUL_LANES + l;
			a = (k / s) * 2 * s + s + k % s;
			t = (k % s) * N_POINTS / (2 * s);
			p_re = longint'(model_re[a]) * tw_cos[t] - longint'(model_im[a]) * tw_nsin[t];
			p_im = longint'(model_re[a]) * tw_nsin[t] + longint'(model_im[a]) * tw_cos[t];
			nre[a] = wrap16(p_re >>> FRAC_W);
			nim[a] = wrap16(p_im >>> FRAC_W);
		end
	end
	model_re = nre;
	model_im = nim;
endtask

// File: dv/fft_tb.sv
module fft_tb import fft_num_pkg::*, fft_ctrl_pkg::*; ();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int CLK_PERIOD = 8;
	localparam int FULL_CMDS = 2 + LOG2_N + MUL_GROUPS * (LOG2_N - 1);
	// load/hold, butterfly, twiddle, impulse plus two frames, reorder
	localparam int TOTAL_CMDS = 4 + 2 + (2 + MUL_GROUPS) + 3 * FULL_CMDS + 2;
	localparam int TIMEOUT_NS = (TOTAL_CMDS * 2 + 20) * CLK_PERIOD * 4;

	logic clk = 1'b0;
	logic reset;
	sample_t sample_in [N_POINTS];
	stage_sel_t stage_select;
	mul_group_t mul_count;
	data_t out_real [N_POINTS];
	data_t out_imag [N_POINTS];

	`include "fft_tb_model.svh"

	fft_top dut (
		.clk          (clk),
		.reset        (reset),
		.sample_in    (sample_in),
		.stage_select (stage_select),
		.mul_count    (mul_count),
		.out_real     (out_real),
		.out_imag     (out_imag)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// command on the falling edge, result checked one cycle later
	task automatic run_cmd(input int stage, input int group, input string name);
		@(negedge clk);
		stage_select = stage_sel_t'(stage);
		mul_count = mul_group_t'(group);
		model_apply(stage, group);
		@(negedge clk);
		stage_select = '0;     // idle code holds the buffer
		mul_count = '0;
		foreach (out_real[i]) begin
			check($sformatf("%s re[%0d]", name, i), model_re[i], int'(out_real[i]));
			check($sformatf("%s im[%0d]", name, i), model_im[i], int'(out_imag[i]));
		end
	endtask

	task automatic new_frame();
		foreach (sample_in[i]) begin
			sample_in[i] = sample_t'(rand_bits(SAMPLE_W));
		end
	endtask

	task automatic finish_test(input string name, input int errs_before);
		$display("test %s: %s", name, (err_count == errs_before) ? "ok" : "failed");
	endtask

	task automatic full_sequence(input string name);
		run_cmd(STAGE_LOAD, 0, name);
		for (int p = 1; p <= LOG2_N; p++) begin
			run_cmd(2 * p, 0, name);
			for (int g = 0; p < LOG2_N && g < MUL_GROUPS; g++) begin
				run_cmd(2 * p + 1, g, name);
			end
		end
		run_cmd(STAGE_REORDER, 0, name);
	endtask

	task automatic reset_values();
		int e0;
		e0 = err_count;
		foreach (out_real[i]) begin
			check($sformatf("reset re[%0d]", i), 0, int'(out_real[i]));
			check($sformatf("reset im[%0d]", i), 0, int'(out_imag[i]));
		end
		finish_test("reset", e0);
	endtask

	task automatic load_and_hold();
		int e0;
		e0 = err_count;
		new_frame();
		run_cmd(STAGE_LOAD, 0, "load");
		run_cmd(0, 0, "hold code 0");
		run_cmd(10, 1, "hold code 10");
		run_cmd(15, 0, "hold code 15");
		finish_test("load_hold", e0);
	endtask

	task automatic single_butterfly();
		int e0;
		e0 = err_count;
		new_frame();
		run_cmd(STAGE_LOAD, 0, "bfly load");
		run_cmd(2, 0, "bfly span 8");
		finish_test("butterfly", e0);
	endtask

	task automatic twiddle_groups();
		int e0;
		e0 = err_count;
		new_frame();
		run_cmd(STAGE_LOAD, 0, "tw load");
		run_cmd(2, 0, "tw bfly");
		for (int g = 0; g < MUL_GROUPS; g++) begin
			run_cmd(3, g, $sformatf("tw group %0d", g));
		end
		finish_test("twiddle", e0);
	endtask

	task automatic full_transform();
		int e0;
		int amp;
		int re;
		e0 = err_count;
		amp = rand_bits(SAMPLE_W);
		foreach (sample_in[i]) begin
			sample_in[i] = (i == 0) ? sample_t'(amp) : '0;
		end
		full_sequence("impulse");
		// q15 truncation may drop an lsb per twiddle pass
		foreach (out_real[i]) begin
			check($sformatf("impulse im[%0d]", i), 0, int'(out_imag[i]));
			re = int'(out_real[i]);
			check_count++;
			if (re > amp || re < amp - LOG2_N) begin
				err_count++;
				$display("ERR impulse re[%0d]: expected %0d to %0d, actual %0d",
					i, amp - LOG2_N, amp, re);
			end
		end
		repeat (2) begin
			new_frame();
			full_sequence("frame");
		end
		finish_test("full", e0);
	endtask

	task automatic reorder_alone();
		int e0;
		e0 = err_count;
		new_frame();
		run_cmd(STAGE_LOAD, 0, "reorder load");
		run_cmd(STAGE_REORDER, 0, "reorder");
		foreach (sample_in[i]) begin
			check($sformatf("reorder at %0d", bit_reverse(i)), int'(sample_in[i]),
				int'(out_real[bit_reverse(i)]));
		end
		finish_test("reorder", e0);
	endtask

	initial begin
		reset = 1'b1;
		stage_select = '0;
		mul_count = '0;
		foreach (sample_in[i]) begin
			sample_in[i] = '0;
		end
		build_twiddles();
		repeat (2) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		reset_values();
		load_and_hold();
		single_butterfly();
		twiddle_groups();
		full_transform();
		reorder_alone();
		$display("checks: %0d, errors: %0d", check_count, err_count);
		if (err_count == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

	initial begin
		#(TIMEOUT_NS);
		$display("watchdog: run did not end within %0d ns", TIMEOUT_NS);
		$display("RESULT: FAIL");
		$finish;
	end

endmodule

// File: sim.f
+incdir+dv
design/fft_num_pkg.sv
design/fft_ctrl_pkg.sv
design/fft_stage_if.sv
design/fft_stage_decode.sv
design/fft_execute.sv
design/fft_buffer.sv
design/fft_top.sv
dv/fft_tb.sv
